//--- bram_256_72.sv
`timescale 1ns/10ps

module bram_256_72 (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [ecc_pkg::ADDR_W-1:0]  addr,
    input  logic                        en,
    input  logic                        we,
    input  logic [ecc_pkg::WORD_W-1:0]  wr,
    output logic [ecc_pkg::WORD_W-1:0]  rd
);

    localparam int DEPTH  = 2 ** ecc_pkg::ADDR_W;
    localparam int HALF_W = ecc_pkg::WORD_W / 2;   // 32 data + 4 parity per port

    // Port A slot (even half-address) and port B slot (odd half-address)
    logic [HALF_W-1:0] mem_hi [DEPTH];
    logic [HALF_W-1:0] mem_lo [DEPTH];

    logic [HALF_W-1:0] wr_hi;
    logic [HALF_W-1:0] wr_lo;
    logic [HALF_W-1:0] dout_hi;
    logic [HALF_W-1:0] dout_lo;

    // Same split as the 36-bit block wrapper
    assign wr_hi = {wr[71:68], wr[63:32]};
    assign wr_lo = {wr[67:64], wr[31:0]};

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_hi[i] = '0;
            mem_lo[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en && we) begin
            mem_hi[addr] <= wr_hi;
            mem_lo[addr] <= wr_lo;
        end
    end

    // Registered output, write-first on a write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_hi <= '0;
            dout_lo <= '0;
        end else if (en) begin
            dout_hi <= we ? wr_hi : mem_hi[addr];
            dout_lo <= we ? wr_lo : mem_lo[addr];
        end
    end

    assign rd = {dout_hi[35:32], dout_lo[35:32], dout_hi[31:0], dout_lo[31:0]};

endmodule

//--- ecc_err_log.sv
`timescale 1ns/10ps

module ecc_err_log #(
    parameter int CNT_W = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_valid,
    input  logic                        corrected,
    input  logic                        uncorrectable,
    input  logic [ecc_pkg::ADDR_W-1:0]  err_addr,
    output logic [CNT_W-1:0]            corr_count,
    output logic [CNT_W-1:0]            uncorr_count,
    output logic [ecc_pkg::ADDR_W-1:0]  last_err_addr
);

    logic hit_corr;
    logic hit_uncorr;

    // Sticks at all ones
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt);
        return (cnt == '1) ? cnt : cnt + 1'b1;
    endfunction

    assign hit_corr   = rd_valid && corrected;
    assign hit_uncorr = rd_valid && uncorrectable;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            corr_count    <= '0;
            uncorr_count  <= '0;
            last_err_addr <= '0;
        end else begin
            if (hit_corr) begin
                corr_count <= sat_inc(corr_count);
            end
            if (hit_uncorr) begin
                uncorr_count <= sat_inc(uncorr_count);
            end
            // Latest flagged read of either kind
            if (hit_corr || hit_uncorr) begin
                last_err_addr <= err_addr;
            end
        end
    end

endmodule

//--- ecc_mem_assert.sv
`timescale 1ns/10ps

module ecc_mem_assert (
    input logic clk,
    input logic rst_n,
    input logic rd_req,
    input logic rd_valid,
    input logic corrected,
    input logic uncorrectable
);

    int fail_cnt = 0;   // Failed properties so far

    // Two stages from request to result in both directions
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req |-> ##2 rd_valid)
        else begin
            fail_cnt++;
            $error("rd_valid missing two cycles after rd_req");
        end

    a_no_stray_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(rd_req, 2))
        else begin
            fail_cnt++;
            $error("rd_valid without rd_req two cycles before");
        end

    a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(corrected && uncorrectable))
        else begin
            fail_cnt++;
            $error("corrected and uncorrectable high together");
        end

    a_flag_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (corrected || uncorrectable) |-> rd_valid)
        else begin
            fail_cnt++;
            $error("Error flag high without rd_valid");
        end

endmodule

bind secded_dec ecc_mem_assert u_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_req        (rd_req),
    .rd_valid      (rd_valid),
    .corrected     (corrected),
    .uncorrectable (uncorrectable)
);

//--- ecc_mem_top.sv
`timescale 1ns/10ps

module ecc_mem_top #(
    parameter int CNT_W = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [ecc_pkg::ADDR_W-1:0]  addr,
    input  logic                        en,
    input  logic                        we,
    input  logic [ecc_pkg::DATA_W-1:0]  wr_data,
    input  logic [ecc_pkg::WORD_W-1:0]  flip_mask,
    output logic [ecc_pkg::DATA_W-1:0]  rd_data,
    output logic                        rd_valid,
    output logic                        corrected,
    output logic                        uncorrectable,
    output logic [CNT_W-1:0]            corr_count,
    output logic [CNT_W-1:0]            uncorr_count,
    output logic [ecc_pkg::ADDR_W-1:0]  last_err_addr
);

    logic [ecc_pkg::WORD_W-1:0] code_word;   // Encoder to RAM
    logic [ecc_pkg::WORD_W-1:0] ram_rd;      // RAM to decoder
    logic                       rd_req;
    logic [ecc_pkg::ADDR_W-1:0] err_addr;

    assign rd_req = en && !we;   // Writes never produce rd_valid

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////
    secded_enc u_enc (
        .data      (wr_data),
        .flip_mask (flip_mask),
        .code_word (code_word)
    );

    bram_256_72 u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .en    (en),
        .we    (we),
        .wr    (code_word),
        .rd    (ram_rd)
    );

    ////////////////////////////////////////////////////////////
    // Read path and error log
    ////////////////////////////////////////////////////////////
    secded_dec u_dec (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_req        (rd_req),
        .addr          (addr),
        .code_word     (ram_rd),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .corrected     (corrected),
        .uncorrectable (uncorrectable),
        .err_addr      (err_addr)
    );

    ecc_err_log #(
        .CNT_W (CNT_W)
    ) u_log (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid      (rd_valid),
        .corrected     (corrected),
        .uncorrectable (uncorrectable),
        .err_addr      (err_addr),
        .corr_count    (corr_count),
        .uncorr_count  (uncorr_count),
        .last_err_addr (last_err_addr)
    );

endmodule

//--- ecc_pkg.sv
package ecc_pkg;

    ////////////////////////////////////////////////////////////
    // Word layout
    ////////////////////////////////////////////////////////////
    localparam int DATA_W = 64;                  // User data bits
    localparam int CHK_W  = 8;                   // Hamming bits plus overall parity
    localparam int WORD_W = DATA_W + CHK_W;      // Stored codeword, check byte on top
    localparam int ADDR_W = 8;                   // 256 words
    localparam int SYN_W  = 7;                   // Hamming syndrome width

    ////////////////////////////////////////////////////////////
    // Hamming position of data bit k
    ////////////////////////////////////////////////////////////
    // Data takes the positions that are not powers of two, from 3 up.
    // Bit 0 lands on 3, bit 1 on 5, bit 2 on 6, bit 63 on 71
    function automatic logic [SYN_W-1:0] data_pos(input int k);
        int cnt;
        logic [SYN_W-1:0] pos;
        cnt = 0;
        pos = '0;
        for (int p = 3; p < 2 ** SYN_W; p++) begin
            if ((p & (p - 1)) != 0) begin        // Skip check bit slots
                if (cnt == k) begin
                    pos = SYN_W'(p);
                end
                cnt++;
            end
        end
        return pos;
    endfunction

endpackage

//--- secded_dec.sv
`timescale 1ns/10ps

module secded_dec (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_req,
    input  logic [ecc_pkg::ADDR_W-1:0]  addr,
    input  logic [ecc_pkg::WORD_W-1:0]  code_word,
    output logic [ecc_pkg::DATA_W-1:0]  rd_data,
    output logic                        rd_valid,
    output logic                        corrected,
    output logic                        uncorrectable,
    output logic [ecc_pkg::ADDR_W-1:0]  err_addr
);

    logic                        req_q;     // Lines up with RAM output
    logic [ecc_pkg::ADDR_W-1:0]  addr_q;
    logic [ecc_pkg::SYN_W-1:0]   syn;
    logic                        par_odd;
    logic [ecc_pkg::DATA_W-1:0]  fixed;
    logic                        single_err;
    logic                        double_err;

    ////////////////////////////////////////////////////////////
    // Stage 1: match the RAM read latency
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            addr_q <= addr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Syndrome and correction
    ////////////////////////////////////////////////////////////
    always_comb begin : decode
        logic [ecc_pkg::SYN_W-1:0] calc;
        logic [ecc_pkg::SYN_W-1:0] pos;
        calc = '0;
        pos  = '0;
        for (int k = 0; k < ecc_pkg::DATA_W; k++) begin
            pos = ecc_pkg::data_pos(k);
            for (int i = 0; i < ecc_pkg::SYN_W; i++) begin
                if (pos[i]) begin
                    calc[i] = calc[i] ^ code_word[k];
                end
            end
        end
        syn     = calc ^ code_word[ecc_pkg::DATA_W +: ecc_pkg::SYN_W];
        par_odd = ^code_word;                 // Odd means one bit flipped

        // Flip back the data bit the syndrome points at, if any
        fixed = code_word[ecc_pkg::DATA_W-1:0];
        if (par_odd) begin
            for (int k = 0; k < ecc_pkg::DATA_W; k++) begin
                if (ecc_pkg::data_pos(k) == syn) begin
                    fixed[k] = ~fixed[k];
                end
            end
        end
    end

    assign single_err = par_odd;                   // Includes check bit 7 alone
    assign double_err = (syn != '0) && !par_odd;   // Raw data passes through

    ////////////////////////////////////////////////////////////
    // Stage 2: registered result
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid      <= 1'b0;
            corrected     <= 1'b0;
            uncorrectable <= 1'b0;
        end else begin
            rd_valid      <= req_q;
            corrected     <= req_q && single_err;
            uncorrectable <= req_q && double_err;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q) begin
            rd_data  <= fixed;
            err_addr <= addr_q;   // Address of the word just read
        end
    end

endmodule

//--- secded_enc.sv
`timescale 1ns/10ps

module secded_enc (
    input  logic [ecc_pkg::DATA_W-1:0] data,
    input  logic [ecc_pkg::WORD_W-1:0] flip_mask,
    output logic [ecc_pkg::WORD_W-1:0] code_word
);

    logic [ecc_pkg::CHK_W-1:0] chk;

    // Check bit i covers every data bit whose position has bit i set
    always_comb begin : calc_chk
        logic [ecc_pkg::SYN_W-1:0] pos;
        chk = '0;
        pos = '0;
        for (int k = 0; k < ecc_pkg::DATA_W; k++) begin
            pos = ecc_pkg::data_pos(k);
            for (int i = 0; i < ecc_pkg::SYN_W; i++) begin
                if (pos[i]) begin
                    chk[i] = chk[i] ^ data[k];
                end
            end
        end
        // Overall parity over data and the seven Hamming bits
        chk[ecc_pkg::CHK_W-1] = (^data) ^ (^chk[ecc_pkg::SYN_W-1:0]);
    end

    // Mask lets a test corrupt the stored word on purpose
    assign code_word = {chk, data} ^ flip_mask;

endmodule

//--- tb_ecc_mem.sv
`timescale 1ns/10ps

module tb_ecc_mem;

    localparam int CNT_W       = 4;                  // Small so saturation is reached
    localparam int CNT_MAX     = 2 ** CNT_W - 1;
    localparam int TIMEOUT_CYC = 3000;               // About 1100 cycles of tests plus margin

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic [ecc_pkg::ADDR_W-1:0]  addr;
    logic                        en;
    logic                        we;
    logic [ecc_pkg::DATA_W-1:0]  wr_data;
    logic [ecc_pkg::WORD_W-1:0]  flip_mask;
    logic [ecc_pkg::DATA_W-1:0]  rd_data;
    logic                        rd_valid;
    logic                        corrected;
    logic                        uncorrectable;
    logic [CNT_W-1:0]            corr_count;
    logic [CNT_W-1:0]            uncorr_count;
    logic [ecc_pkg::ADDR_W-1:0]  last_err_addr;

    logic [ecc_pkg::WORD_W-1:0]  shadow [256];      // Stored words after the mask
    logic [65:0]                 exp_q [$];         // {uncorrectable, corrected, data}
    logic [ecc_pkg::ADDR_W-1:0]  exp_addr_q [$];
    int                          due_q [$];         // Cycle at which rd_valid is due
    int                          cycle = 0;
    int                          errors = 0;
    int                          tally_corr;
    int                          tally_uncorr;
    logic [ecc_pkg::ADDR_W-1:0]  ref_last;

    ecc_mem_top #(.CNT_W(CNT_W)) UUT (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference code
    ////////////////////////////////////////////////////////////
    function automatic int ham_pos(input int k);
        int p;
        int n;
        p = 2;
        n = -1;
        while (n < k) begin
            p++;
            if ((p & (p - 1)) != 0) begin    // Powers of two hold check bits
                n++;
            end
        end
        return p;
    endfunction

    function automatic logic [71:0] encode_word(input logic [63:0] d);
        logic [7:0] chk;
        int p;
        chk = '0;
        for (int k = 0; k < 64; k++) begin
            p = ham_pos(k);
            for (int i = 0; i < 7; i++) begin
                if (p[i]) begin
                    chk[i] = chk[i] ^ d[k];
                end
            end
        end
        chk[7] = (^d) ^ (^chk[6:0]);
        return {chk, d};
    endfunction

    // Syndrome as the XOR of the positions of all set data bits
    function automatic logic [65:0] decode_word(input logic [71:0] w);
        logic [6:0]  syn;
        logic [63:0] d;
        syn = w[70:64];
        d   = w[63:0];
        for (int k = 0; k < 64; k++) begin
            syn = syn ^ (w[k] ? 7'(ham_pos(k)) : 7'd0);
        end
        if (^w) begin
            for (int k = 0; k < 64; k++) begin
                if (ham_pos(k) == syn) begin
                    d[k] = ~d[k];
                end
            end
            return {2'b01, d};
        end
        return {(syn != 7'd0), 1'b0, d};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expv,
                                   input logic [63:0] actv);
        $display("[ERROR] %s expected %h got %h at cycle %0d", name, expv, actv, cycle);
        errors++;
    endtask

    task automatic write_word(input int a, input logic [63:0] d, input logic [71:0] m);
        @(posedge clk);
        #0.5;
        en        = 1'b1;
        we        = 1'b1;
        addr      = a;
        wr_data   = d;
        flip_mask = m;
        shadow[a] = encode_word(d) ^ m;
    endtask

    task automatic read_word(input int a);
        @(posedge clk);
        #0.5;
        en        = 1'b1;
        we        = 1'b0;
        addr      = a;
        flip_mask = '0;
        exp_q.push_back(decode_word(shadow[a]));
        exp_addr_q.push_back(a);
        due_q.push_back(cycle + 2);
    endtask

    task automatic drain_reads();
        @(posedge clk);
        #0.5;
        en = 1'b0;
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);     // Let the counters settle
    endtask

    ////////////////////////////////////////////////////////////
    // Compare on the falling edge with counters one cycle behind
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin : compare
        logic [65:0] exp_word;
        logic [7:0]  exp_addr;
        int          due;
        if (!rst_n) begin
            tally_corr   = 0;
            tally_uncorr = 0;
            ref_last     = '0;
            exp_q.delete();                // Reads in flight are dropped by reset
            exp_addr_q.delete();
            due_q.delete();
        end else begin
            if (corr_count !== tally_corr[CNT_W-1:0])
                report_mismatch("corr_count", tally_corr, corr_count);
            if (uncorr_count !== tally_uncorr[CNT_W-1:0])
                report_mismatch("uncorr_count", tally_uncorr, uncorr_count);
            if (last_err_addr !== ref_last)
                report_mismatch("last_err_addr", ref_last, last_err_addr);
            if (!rd_valid && (corrected || uncorrectable)) begin
                $display("Error flag high without rd_valid at cycle %0d", cycle);
                errors++;
            end
            if (due_q.size() != 0 && cycle > due_q[0]) begin
                $display("Read of address %0d never produced rd_valid", exp_addr_q[0]);
                errors++;
                void'(exp_q.pop_front());
                void'(exp_addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (rd_valid && due_q.size() == 0) begin
                $display("rd_valid at cycle %0d with no read outstanding", cycle);
                errors++;
            end else if (rd_valid) begin
                exp_word = exp_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                due      = due_q.pop_front();
                if (due != cycle) begin
                    $display("rd_valid came at cycle %0d, due at cycle %0d", cycle, due);
                    errors++;
                end
                if (rd_data !== exp_word[63:0])
                    report_mismatch("rd_data", exp_word[63:0], rd_data);
                if (corrected !== exp_word[64])
                    report_mismatch("corrected", exp_word[64], corrected);
                if (uncorrectable !== exp_word[65])
                    report_mismatch("uncorrectable", exp_word[65], uncorrectable);
                if (exp_word[64] || exp_word[65])
                    ref_last = exp_addr;
                if (exp_word[64] && tally_corr < CNT_MAX)
                    tally_corr++;
                if (exp_word[65] && tally_uncorr < CNT_MAX)
                    tally_uncorr++;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin : stimulus
        logic [71:0] m;
        int          p1;
        void'($urandom(32'h9686));
        rst_n     = 1'b0;
        en        = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        flip_mask = '0;
        repeat (2) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        for (int a = 0; a < 256; a++) write_word(a, {$urandom, $urandom}, '0);
        for (int a = 0; a < 256; a++) read_word(a);    // Back to back
        drain_reads();

        // One flip at every codeword bit, check byte included
        for (int b = 0; b < 72; b++) write_word(b, {$urandom, $urandom}, 72'd1 << b);
        for (int b = 0; b < 72; b++) read_word(b);
        drain_reads();
        if (corr_count !== 4'hf) report_mismatch("corr_count", 64'hf, corr_count);

        for (int a = 72; a < 112; a++) begin
            m  = '0;
            p1 = $urandom_range(71, 0);
            m[p1] = 1'b1;
            m[(p1 + 1 + $urandom_range(70, 0)) % 72] = 1'b1;   // Always a second bit
            write_word(a, {$urandom, $urandom}, m);
        end
        for (int a = 72; a < 112; a++) read_word(a);
        drain_reads();
        if (uncorr_count !== 4'hf) report_mismatch("uncorr_count", 64'hf, uncorr_count);

        // Reset mid-run while flagged reads are in flight
        for (int a = 72; a < 76; a++) read_word(a);
        @(posedge clk);
        #0.5;
        rst_n = 1'b0;
        en    = 1'b0;
        repeat (2) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        for (int a = 0; a < 256; a++) begin
            read_word(a);
            if (a % 32 == 31) drain_reads();           // Idle gaps with en low
        end
        drain_reads();

        errors += UUT.u_dec.u_assert.fail_cnt;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- vlog.f
ecc_pkg.sv
secded_enc.sv
bram_256_72.sv
secded_dec.sv
ecc_err_log.sv
ecc_mem_top.sv
ecc_mem_assert.sv
tb_ecc_mem.sv
